//--- tb.f
+incdir+include
design/ppu_pkg.sv
design/ppu_ram.sv
design/vram_port.sv
design/cgram_port.sv
design/hv_timing.sv
design/ppu_cpu_port.sv
sim/ppu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PPU CPU port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ppu_tb -f tb.f -o ppu_tb

output=$(./obj_dir/ppu_tb)
echo "$output"

if echo "$output" | grep -q "^Simulation finished: PASS$"; then
    exit 0
fi
exit 1

//--- sim/ppu_tb.sv
// Bus-level testbench for the PPU CPU port
// Strobes are spaced 4 cycles apart and rdata is sampled mid-cycle
// The palette RAM has no reset, so it is only read after it is written
`timescale 1ns/10ps
`default_nettype none
`include "ppu_cfg.svh"

module ppu_tb;

    import ppu_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int LINE_CYCLES = `PPU_H_TOTAL * `PPU_CLKS_PER_DOT;
    localparam int SEQ_WORDS   = 16;
    localparam int REMAP_RUNS  = 5;
    localparam int REMAP_WORDS = 8;
    localparam int CG_COLOURS  = 16;
    localparam int MPY_PAIRS   = 40;
    localparam int STROBES = 10 + 4 * SEQ_WORDS + 5 + REMAP_RUNS * (3 + 6 * REMAP_WORDS) + 1
        + 4 * CG_COLOURS + 2 + 7 * MPY_PAIRS + 16;
    localparam int TEST_CYCLES     = 10 + 3 * LINE_CYCLES + 4 * STROBES;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 500;

    logic        clk = 1'b0;
    logic        reset;
    logic        cpu_en;
    b_op_type    b_op;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    ctr_t        h_ctr;
    ctr_t        v_ctr;
    logic [11:0] frame_ctr;

    // Values seen during the last strobe
    logic [7:0]  rd_sample;
    ctr_t        h_sample;
    ctr_t        v_sample;
    logic [11:0] frame_sample;

    logic [31:0] lcg_state = 32'd16965;
    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    logic [15:0] vram_model [`PPU_VRAM_WORDS];
    logic [14:0] cgram_model [`PPU_CGRAM_ENTRIES];

    always #(CLK_PERIOD / 2) clk = ~clk;

    ppu_cpu_port i_ppu_cpu_port (
        .clk       (clk),
        .reset     (reset),
        .cpu_en    (cpu_en),
        .b_op      (b_op),
        .wdata     (wdata),
        .rdata     (rdata),
        .h_ctr     (h_ctr),
        .v_ctr     (v_ctr),
        .frame_ctr (frame_ctr)
    );

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Low 7+mode bits rotate left by 3
    function automatic logic [14:0] remap_addr(input logic [14:0] a, input int mode);
        logic [14:0] r;
        int          n;
        r = a;
        if (mode != 0) begin
            n = 7 + mode;
            for (int i = 0; i < n; i++) begin
                r[(i + 3) % n] = a[i];
            end
        end
        return r;
    endfunction

    function automatic logic [14:0] step_size(input int mode);
        return (mode == 0) ? 15'd1 : (mode == 1) ? 15'd32 : 15'd128;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input logic [11:0] exp,
                               input logic [11:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic bus_op(input b_op_type op, input logic [7:0] data);
        @(posedge clk);
        cpu_en <= 1'b1;
        b_op   <= op;
        wdata  <= data;
        @(negedge clk);
        rd_sample    = rdata;
        h_sample     = h_ctr;
        v_sample     = v_ctr;
        frame_sample = frame_ctr;
        @(posedge clk);
        cpu_en <= 1'b0;
        b_op   <= B_NOP;
        wdata  <= 8'h0;
        repeat (2) @(posedge clk);
    endtask

    task automatic read_check(input b_op_type op, input logic [7:0] exp, input string name);
        bus_op(op, 8'h0);
        check_byte(name, exp, rd_sample);
    endtask

    task automatic set_vram_addr(input logic [14:0] a);
        bus_op(B_VMADDL, a[7:0]);
        bus_op(B_VMADDH, {1'b0, a[14:8]});
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic reset_and_counters();
        ctr_t exp_h;
        ctr_t exp_v;
        int   exp_div;
        int   err_start;
        err_start = errors;
        exp_h = '0;
        exp_v = '0;
        exp_div = 0;
        for (int c = 0; c < LINE_CYCLES + 40; c++) begin
            @(negedge clk);
            if (c == 0) begin
                check_count("frame_ctr", 12'h0, frame_ctr);
            end
            check_count("h_ctr", 12'(exp_h), 12'(h_ctr));
            check_count("v_ctr", 12'(exp_v), 12'(v_ctr));
            if (exp_div == `PPU_CLKS_PER_DOT - 1) begin
                exp_div = 0;
                if (exp_h == 9'(`PPU_H_TOTAL - 1)) begin
                    exp_h = '0;
                    exp_v = exp_v + 9'd1;
                end else begin
                    exp_h = exp_h + 9'd1;
                end
            end else begin
                exp_div++;
            end
        end
        // High byte first, the low read moves the address
        read_check(B_NOP, 8'h00, "rdata NOP");
        read_check(B_RDVRAMH, 8'h00, "rdata RDVRAMH");
        read_check(B_RDVRAML, 8'h00, "rdata RDVRAML");
        read_check(B_MPYL, 8'h00, "rdata MPYL");
        read_check(B_MPYM, 8'h00, "rdata MPYM");
        read_check(B_MPYH, 8'h00, "rdata MPYH");
        read_check(B_OPHCT, 8'h00, "rdata OPHCT");
        read_check(B_OPVCT, 8'h00, "rdata OPVCT");
        read_check(B_STAT78, {4'h0, 4'(`PPU_VERSION)}, "rdata STAT78");
        report_test("reset values and H/V counting", err_start);
    endtask

    task automatic vram_sequential();
        logic [14:0] start;
        logic [14:0] a;
        logic [15:0] w;
        int          err_start;
        err_start = errors;
        start = 15'({rand_byte(), rand_byte()});
        bus_op(B_VMAIN, 8'h80);
        set_vram_addr(start);
        a = start;
        for (int i = 0; i < SEQ_WORDS; i++) begin
            w = {rand_byte(), rand_byte()};
            vram_model[a] = w;
            bus_op(B_VMDATAL, w[7:0]);
            bus_op(B_VMDATAH, w[15:8]);
            a = a + 15'd1;
        end
        set_vram_addr(start);
        a = start;
        for (int i = 0; i < SEQ_WORDS; i++) begin
            read_check(B_RDVRAML, vram_model[a][7:0], "rdata RDVRAML");
            read_check(B_RDVRAMH, vram_model[a][15:8], "rdata RDVRAMH");
            a = a + 15'd1;
        end
        report_test("VRAM sequential, step 1", err_start);
    endtask

    task automatic vram_step_remap();
        int          step_modes [REMAP_RUNS] = '{1, 2, 3, 1, 2};
        int          remap_modes [REMAP_RUNS] = '{1, 2, 3, 3, 1};
        logic [14:0] written [$];
        logic [14:0] a;
        logic [14:0] phys;
        logic [15:0] w;
        int          err_start;
        err_start = errors;
        for (int r = 0; r < REMAP_RUNS; r++) begin
            bus_op(B_VMAIN, {1'b1, 3'b000, 2'(remap_modes[r]), 2'(step_modes[r])});
            a = 15'({rand_byte(), rand_byte()});
            set_vram_addr(a);
            for (int i = 0; i < REMAP_WORDS; i++) begin
                w = {rand_byte(), rand_byte()};
                phys = remap_addr(a, remap_modes[r]);
                vram_model[phys] = w;
                written.push_back(phys);
                bus_op(B_VMDATAL, w[7:0]);
                bus_op(B_VMDATAH, w[15:8]);
                a = a + step_size(step_modes[r]);
            end
        end
        // Identity mapping to see where each word landed
        bus_op(B_VMAIN, 8'h80);
        foreach (written[k]) begin
            set_vram_addr(written[k]);
            read_check(B_RDVRAML, vram_model[written[k]][7:0], "rdata RDVRAML");
            read_check(B_RDVRAMH, vram_model[written[k]][15:8], "rdata RDVRAMH");
        end
        report_test("VRAM steps 32/128 with remap", err_start);
    endtask

    task automatic cgram_colours();
        logic [7:0]  start;
        logic [7:0]  idx;
        logic [15:0] c;
        int          err_start;
        err_start = errors;
        start = rand_byte();
        bus_op(B_CGADD, start);
        idx = start;
        for (int i = 0; i < CG_COLOURS; i++) begin
            c = {rand_byte(), rand_byte()};
            if (i % 2 == 0) begin
                c[15] = 1'b1;
            end
            cgram_model[idx] = c[14:0];
            bus_op(B_CGDATA, c[7:0]);
            bus_op(B_CGDATA, c[15:8]);
            idx = idx + 8'd1;
        end
        bus_op(B_CGADD, start);
        idx = start;
        for (int i = 0; i < CG_COLOURS; i++) begin
            read_check(B_RDCGRAM, cgram_model[idx][7:0], "rdata RDCGRAM low");
            read_check(B_RDCGRAM, {1'b0, cgram_model[idx][14:8]}, "rdata RDCGRAM high");
            idx = idx + 8'd1;
        end
        report_test("CGRAM write and readback", err_start);
    endtask

    task automatic multiply_products();
        logic signed [15:0] a_val;
        logic [15:0]        b_val;
        logic signed [7:0]  b_hi;
        int                 prod;
        int                 err_start;
        err_start = errors;
        for (int i = 0; i < MPY_PAIRS; i++) begin
            a_val = {rand_byte(), rand_byte()};
            b_val = {rand_byte(), rand_byte()};
            bus_op(B_M7A, a_val[7:0]);
            bus_op(B_M7A, a_val[15:8]);
            bus_op(B_M7B, b_val[7:0]);
            bus_op(B_M7B, b_val[15:8]);
            b_hi = b_val[15:8];
            prod = int'(a_val) * int'(b_hi);
            read_check(B_MPYL, prod[7:0], "rdata MPYL");
            read_check(B_MPYM, prod[15:8], "rdata MPYM");
            read_check(B_MPYH, prod[23:16], "rdata MPYH");
        end
        report_test("signed multiplier", err_start);
    endtask

    task automatic hv_latch_reads();
        ctr_t h_latched;
        ctr_t v_latched;
        int   waited;
        int   err_start;
        err_start = errors;
        for (int round = 0; round < 2; round++) begin
            bus_op(B_STAT78, 8'h0);
            // Upper half of the line first so H bit 8 is set
            waited = 0;
            while ((h_ctr[8] != (round == 0)) && (waited < LINE_CYCLES)) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= LINE_CYCLES) begin
                errors++;
                $display("H counter never reached the wanted half of the line at %0t", $time);
            end
            bus_op(B_SLHV, 8'h0);
            h_latched = h_sample;
            v_latched = v_sample;
            read_check(B_OPHCT, h_latched[7:0], "rdata OPHCT low");
            read_check(B_OPHCT, {7'h0, h_latched[8]}, "rdata OPHCT high");
            read_check(B_OPVCT, v_latched[7:0], "rdata OPVCT low");
            read_check(B_OPVCT, {7'h0, v_latched[8]}, "rdata OPVCT high");
            // Field in bit 7, latch flag in bit 6, version below
            bus_op(B_STAT78, 8'h0);
            check_byte("rdata STAT78", {frame_sample[0], 1'b1, 2'b00, 4'(`PPU_VERSION)},
                       rd_sample);
            bus_op(B_STAT78, 8'h0);
            check_byte("rdata STAT78", {frame_sample[0], 1'b0, 2'b00, 4'(`PPU_VERSION)},
                       rd_sample);
        end
        report_test("H/V latch and status", err_start);
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        reset  = 1'b1;
        cpu_en = 1'b0;
        b_op   = B_NOP;
        wdata  = 8'h0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        reset_and_counters();
        vram_sequential();
        vram_step_remap();
        cgram_colours();
        multiply_products();
        hv_latch_reads();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/ppu_cpu_port.sv
// CPU-facing PPU slave covering VRAM, CGRAM, H/V counters and multiplier
// One strobe per cpu_en cycle, rdata is combinational from b_op
// Strobes must be at least 3 cycles apart
`timescale 1ns/10ps
`default_nettype none

module ppu_cpu_port (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cpu_en,
    input  wire ppu_pkg::b_op_type   b_op,
    input  wire [7:0]                wdata,
    output logic [7:0]               rdata,
    output ppu_pkg::ctr_t            h_ctr,
    output ppu_pkg::ctr_t            v_ctr,
    output logic [11:0]              frame_ctr
);

    import ppu_pkg::*;

    logic [7:0]         vram_rd;
    logic [7:0]         cgram_rd;
    logic [7:0]         hv_rd;
    logic [7:0]         mpy_rd;
    logic [15:0]        m7_a;
    logic [7:0]         m7_b;
    logic [7:0]         m7_old;
    logic signed [23:0] product;

    // ------------------------------
    // Sub-units
    // ------------------------------

    vram_port i_vram_port (
        .clk     (clk),
        .reset   (reset),
        .cpu_en  (cpu_en),
        .b_op    (b_op),
        .wdata   (wdata),
        .rd_byte (vram_rd)
    );

    cgram_port i_cgram_port (
        .clk     (clk),
        .reset   (reset),
        .cpu_en  (cpu_en),
        .b_op    (b_op),
        .wdata   (wdata),
        .rd_byte (cgram_rd)
    );

    hv_timing i_hv_timing (
        .clk       (clk),
        .reset     (reset),
        .cpu_en    (cpu_en),
        .b_op      (b_op),
        .h_ctr     (h_ctr),
        .v_ctr     (v_ctr),
        .frame_ctr (frame_ctr),
        .rd_byte   (hv_rd)
    );

    // ------------------------------
    // Multiplier
    // ------------------------------

    // Two writes per register, low byte first
    // Only the high byte of M7B feeds the product
    always_ff @(posedge clk) begin
        if (reset) begin
            m7_a   <= 16'h0;
            m7_b   <= 8'h0;
            m7_old <= 8'h0;
        end else if (cpu_en) begin
            if (b_op == B_M7A) begin
                m7_a   <= {wdata, m7_old};
                m7_old <= wdata;
            end else if (b_op == B_M7B) begin
                m7_b   <= wdata;
                m7_old <= wdata;
            end
        end
    end

    // Signed 16 x 8 product
    assign product = $signed(m7_a) * $signed(m7_b);

    always_comb begin
        case (b_op)
            B_MPYL:  mpy_rd = product[7:0];
            B_MPYM:  mpy_rd = product[15:8];
            B_MPYH:  mpy_rd = product[23:16];
            default: mpy_rd = 8'h0;
        endcase
    end

    // Each source is zero outside its own reads
    assign rdata = vram_rd | cgram_rd | hv_rd | mpy_rd;

endmodule

`default_nettype wire

//--- design/hv_timing.sv
// Dot, line and frame counters with the H/V latch and STAT78
// Non-interlaced timing only, field toggles once per frame
`timescale 1ns/10ps
`default_nettype none
`include "ppu_cfg.svh"

module hv_timing (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cpu_en,
    input  wire ppu_pkg::b_op_type   b_op,
    output ppu_pkg::ctr_t            h_ctr,
    output ppu_pkg::ctr_t            v_ctr,
    output logic [11:0]              frame_ctr,
    output logic [7:0]               rd_byte
);

    import ppu_pkg::*;

    localparam int DIV_W = $clog2(`PPU_CLKS_PER_DOT);

    logic [DIV_W-1:0] dot_div;
    logic             dot_en;
    logic             h_wrap;
    logic             v_wrap;
    logic             field;
    ctr_t             h_latch;
    ctr_t             v_latch;
    logic             latch_flg;
    logic             h_tgl;
    logic             v_tgl;

    // ------------------------------
    // Counters
    // ------------------------------

    assign dot_en = dot_div == DIV_W'(`PPU_CLKS_PER_DOT - 1);
    assign h_wrap = h_ctr == ctr_t'(`PPU_H_TOTAL - 1);
    assign v_wrap = v_ctr == ctr_t'(`PPU_V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            dot_div   <= '0;
            h_ctr     <= '0;
            v_ctr     <= '0;
            frame_ctr <= 12'h0;
            field     <= 1'b0;
        end else begin
            dot_div <= dot_en ? '0 : dot_div + 1'b1;
            if (dot_en) begin
                if (h_wrap) begin
                    h_ctr <= '0;
                    if (v_wrap) begin
                        v_ctr     <= '0;
                        frame_ctr <= frame_ctr + 12'h1;
                        field     <= ~field;
                    end else begin
                        v_ctr <= v_ctr + 1'b1;
                    end
                end else begin
                    h_ctr <= h_ctr + 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // H/V latch
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            h_latch   <= '0;
            v_latch   <= '0;
            latch_flg <= 1'b0;
            h_tgl     <= 1'b0;
            v_tgl     <= 1'b0;
        end else if (cpu_en) begin
            case (b_op)
                B_SLHV: begin
                    h_latch   <= h_ctr;
                    v_latch   <= v_ctr;
                    latch_flg <= 1'b1;
                end
                B_OPHCT: h_tgl <= ~h_tgl;
                B_OPVCT: v_tgl <= ~v_tgl;
                B_STAT78: begin
                    latch_flg <= 1'b0;
                    h_tgl     <= 1'b0;
                    v_tgl     <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (b_op)
            B_OPHCT:  rd_byte = h_tgl ? {7'h0, h_latch[8]} : h_latch[7:0];
            B_OPVCT:  rd_byte = v_tgl ? {7'h0, v_latch[8]} : v_latch[7:0];
            B_STAT78: rd_byte = {field, latch_flg, 2'b00, 4'(`PPU_VERSION)};
            default:  rd_byte = 8'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cgram_port.sv
// Palette access port with byte address and low/high toggle
// Readback relies on strobes being at least 3 cycles apart
`timescale 1ns/10ps
`default_nettype none
`include "ppu_cfg.svh"

module cgram_port (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cpu_en,
    input  wire ppu_pkg::b_op_type   b_op,
    input  wire [7:0]                wdata,
    output logic [7:0]               rd_byte
);

    import ppu_pkg::*;

    cgram_addr_t cg_addr;
    logic        cg_tgl;
    logic        advance;
    logic        we_l;
    logic        we_h;
    logic [7:0]  q_l;
    logic [6:0]  q_h;
    color_t      color;

    assign advance = cpu_en & ((b_op == B_CGDATA) | (b_op == B_RDCGRAM));

    always_ff @(posedge clk) begin
        if (reset) begin
            {cg_addr, cg_tgl} <= 9'h0;
        end else if (cpu_en & (b_op == B_CGADD)) begin
            {cg_addr, cg_tgl} <= {wdata, 1'b0};
        end else if (advance) begin
            {cg_addr, cg_tgl} <= {cg_addr, cg_tgl} + 9'h1;
        end
    end

    // Toggle picks the half
    assign we_l = cpu_en & (b_op == B_CGDATA) & ~cg_tgl;
    assign we_h = cpu_en & (b_op == B_CGDATA) & cg_tgl;

    ppu_ram #(.word_t(logic [7:0]), .DEPTH(`PPU_CGRAM_ENTRIES)) i_cgram_l (
        .clk   (clk),
        .we    (we_l),
        .addr  (cg_addr),
        .wdata (wdata),
        .q     (q_l)
    );

    ppu_ram #(.word_t(logic [6:0]), .DEPTH(`PPU_CGRAM_ENTRIES)) i_cgram_h (
        .clk   (clk),
        .we    (we_h),
        .addr  (cg_addr),
        .wdata (wdata[6:0]),
        .q     (q_h)
    );

    assign color = {q_h, q_l};

    always_comb begin
        rd_byte = 8'h0;
        if (b_op == B_RDCGRAM) begin
            rd_byte = cg_tgl ? {1'b0, color[14:8]} : color[7:0];
        end
    end

endmodule

`default_nettype wire

//--- design/vram_port.sv
// VRAM access port with increment, address remap and read prefetch
// The prefetch word is ready 2 cycles after an address change
// CPU writes always reach VRAM, there is no renderer arbitration
`timescale 1ns/10ps
`default_nettype none
`include "ppu_cfg.svh"

module vram_port (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cpu_en,
    input  wire ppu_pkg::b_op_type   b_op,
    input  wire [7:0]                wdata,
    output logic [7:0]               rd_byte
);

    import ppu_pkg::*;

    // Bit 4 selects increment on the high byte
    logic [4:0] ctrl;
    vram_addr_t addr_reg;
    vram_addr_t access_addr;
    vram_addr_t ram_addr;
    vram_addr_t step;
    logic       inc_op;
    logic       addr_change;
    logic       fetch_pend;
    logic       fetch_issued;
    vram_word_t prefetch;
    logic [7:0] q_l;
    logic [7:0] q_h;
    logic       we_l;
    logic       we_h;

    // ------------------------------
    // Address path
    // ------------------------------

    assign inc_op = cpu_en & (ctrl[4]
        ? ((b_op == B_VMDATAH) | (b_op == B_RDVRAMH))
        : ((b_op == B_VMDATAL) | (b_op == B_RDVRAML)));

    assign addr_change = inc_op | (cpu_en & ((b_op == B_VMADDL) | (b_op == B_VMADDH)));

    always_comb begin
        case (ctrl[1:0])
            2'd0:    step = 15'd1;
            2'd1:    step = 15'd32;
            default: step = 15'd128;
        endcase
    end

    // Bypass so the address strobe sees its own byte
    always_comb begin
        case (b_op)
            B_VMADDL: access_addr = {addr_reg[14:8], wdata};
            B_VMADDH: access_addr = {wdata[6:0], addr_reg[7:0]};
            default:  access_addr = addr_reg;
        endcase
    end

    // Rotate the low 8, 9 or 10 bits left by 3
    always_comb begin
        case (ctrl[3:2])
            2'd1:    ram_addr = {access_addr[14:8], access_addr[4:0], access_addr[7:5]};
            2'd2:    ram_addr = {access_addr[14:9], access_addr[5:0], access_addr[8:6]};
            2'd3:    ram_addr = {access_addr[14:10], access_addr[6:0], access_addr[9:7]};
            default: ram_addr = access_addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= 5'h0;
        end else if (cpu_en & (b_op == B_VMAIN)) begin
            ctrl <= {wdata[7], wdata[3:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_reg <= '0;
        end else if (cpu_en & (b_op == B_VMADDL)) begin
            addr_reg[7:0] <= wdata;
        end else if (cpu_en & (b_op == B_VMADDH)) begin
            addr_reg[14:8] <= wdata[6:0];
        end else if (inc_op) begin
            addr_reg <= addr_reg + step;
        end
    end

    // ------------------------------
    // RAM and prefetch
    // ------------------------------

    assign we_l = cpu_en & (b_op == B_VMDATAL);
    assign we_h = cpu_en & (b_op == B_VMDATAH);

    ppu_ram #(.word_t(logic [7:0]), .DEPTH(`PPU_VRAM_WORDS)) i_vram_l (
        .clk   (clk),
        .we    (we_l),
        .addr  (ram_addr),
        .wdata (wdata),
        .q     (q_l)
    );

    ppu_ram #(.word_t(logic [7:0]), .DEPTH(`PPU_VRAM_WORDS)) i_vram_h (
        .clk   (clk),
        .we    (we_h),
        .addr  (ram_addr),
        .wdata (wdata),
        .q     (q_h)
    );

    // Read issued the cycle after the change, word captured one later
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pend   <= 1'b0;
            fetch_issued <= 1'b0;
            prefetch     <= '0;
        end else begin
            fetch_pend   <= addr_change;
            fetch_issued <= fetch_pend;
            if (fetch_issued) begin
                prefetch <= {q_h, q_l};
            end
        end
    end

    always_comb begin
        case (b_op)
            B_RDVRAML: rd_byte = prefetch[7:0];
            B_RDVRAMH: rd_byte = prefetch[15:8];
            default:   rd_byte = 8'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/ppu_ram.sv
// Single-port RAM with registered read and no reset
// A read during a write returns the old word
`timescale 1ns/10ps
`default_nettype none

module ppu_ram #(
    parameter type word_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  wire                      clk,
    input  wire                      we,
    input  wire [$clog2(DEPTH)-1:0]  addr,
    input  wire word_t               wdata,
    output word_t                    q
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

`default_nettype wire

//--- design/ppu_pkg.sv
// Bus operation codes and the data types shared by the PPU CPU port
// Operation codes follow the low byte of the B-bus register address
`default_nettype none

package ppu_pkg;

    // ------------------------------
    // Bus operations
    // ------------------------------

    typedef enum logic [7:0] {
        B_NOP     = 8'h00,
        B_VMAIN   = 8'h15,
        B_VMADDL  = 8'h16,
        B_VMADDH  = 8'h17,
        B_VMDATAL = 8'h18,
        B_VMDATAH = 8'h19,
        B_M7A     = 8'h1b,
        B_M7B     = 8'h1c,
        B_CGADD   = 8'h21,
        B_CGDATA  = 8'h22,
        B_MPYL    = 8'h34,
        B_MPYM    = 8'h35,
        B_MPYH    = 8'h36,
        B_SLHV    = 8'h37,
        B_RDVRAML = 8'h39,
        B_RDVRAMH = 8'h3a,
        B_RDCGRAM = 8'h3b,
        B_OPHCT   = 8'h3c,
        B_OPVCT   = 8'h3d,
        B_STAT78  = 8'h3f
    } b_op_type;

    // ------------------------------
    // Data types
    // ------------------------------

    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    typedef logic [7:0] cgram_addr_t;

    // Blue in the top bits, red in the bottom
    typedef struct packed {
        logic [4:0] b;
        logic [4:0] g;
        logic [4:0] r;
    } color_t;

    // Shared by the H and V counters
    typedef logic [8:0] ctr_t;

endpackage

`default_nettype wire

//--- include/ppu_cfg.svh
// Sizes and timing constants for the PPU CPU port
// Counter totals describe one 262-line frame without interlace
// The RAM depths must be powers of two
`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// ------------------------------
// RAM depths
// ------------------------------

// VRAM words, each split into two byte-wide halves
`define PPU_VRAM_WORDS 32768

// Palette entries of 15 bits
`define PPU_CGRAM_ENTRIES 256

// ------------------------------
// Video timing
// ------------------------------

`define PPU_CLKS_PER_DOT 4
`define PPU_H_TOTAL 340
`define PPU_V_TOTAL 262

// Returned in the low nibble of STAT78
`define PPU_VERSION 2

`endif
